//--- logic/cdc_params.svh
`ifndef CDC_PARAMS_SVH
`define CDC_PARAMS_SVH

// Configuration word carried by the write channel
`define CDC_DATA_W 16

// Number of completed writes kept in the status word
`define CDC_CNT_W 8

// Status word is the write count on top of the register value
`define CDC_STAT_W (`CDC_CNT_W + `CDC_DATA_W)

// Flip-flops in each phase synchronizer chain
`define CDC_SYNC_STAGES 2

`endif

//--- logic/cdc_pkg.sv
`include "cdc_params.svh"

package cdc_pkg;

  // Configuration word written into the destination register
  typedef logic [`CDC_DATA_W-1:0] word_t;

  // Status word read back by the source
  typedef logic [`CDC_STAT_W-1:0] stat_t;

  // Wrapping count of completed writes
  typedef logic [`CDC_CNT_W-1:0] cnt_t;

  // Handshake FSM state on either side of the crossing
  typedef enum logic {
    HS_IDLE,
    HS_BUSY
  } hs_state_e;

endpackage

//--- logic/xfer_if.sv
`timescale 1ns/1ps

// One request/acknowledge channel with its data, both clock domains
interface xfer_if #(
  parameter int unsigned Width = 16
);
  // Source domain side
  logic             src_req;
  logic             src_ack;
  logic [Width-1:0] src_data;

  // Destination domain side
  logic             dst_req;
  logic             dst_ack;
  logic [Width-1:0] dst_data;

  // Data as delivered by the synchronizer to the receiving side
  logic [Width-1:0] sync_data;

  // Requesting port in the source domain
  modport src_mp (output src_req, output src_data, input src_ack, input sync_data);

  // Answering port in the destination domain
  modport dst_mp (output dst_ack, output dst_data, input dst_req, input sync_data);

  // Synchronizer sits between the two ports
  modport sync_mp (
    input  src_req,
    input  src_data,
    input  dst_ack,
    input  dst_data,
    output src_ack,
    output dst_req,
    output sync_data
  );

endinterface

//--- logic/sync_reqack.sv
`timescale 1ns/1ps
`include "cdc_params.svh"

module sync_reqack (
  input  logic clk_src_i,
  input  logic clk_dst_i,
  input  logic effective_rst_n,
  input  logic src_req_i,
  output logic src_ack_o,
  output logic dst_req_o,
  input  logic dst_ack_i
);
  import cdc_pkg::*;

  // Source side FSM and request phase
  hs_state_e                   src_state_q;
  hs_state_e                   src_state_d;
  logic                        src_phase_q;
  logic                        src_toggle;
  logic [`CDC_SYNC_STAGES-1:0] ack_sync_q;
  logic                        ack_phase;

  // Destination side FSM and acknowledge phase
  hs_state_e                   dst_state_q;
  hs_state_e                   dst_state_d;
  logic                        dst_phase_q;
  logic                        dst_toggle;
  logic [`CDC_SYNC_STAGES-1:0] req_sync_q;
  logic                        req_phase;

  //////////////////////////////////////////////////
  // Source domain
  //////////////////////////////////////////////////

  // Acknowledge phase brought back from the destination
  assign ack_phase = ack_sync_q[`CDC_SYNC_STAGES-1];

  always_comb begin
    src_state_d = src_state_q;
    src_toggle  = 1'b0;
    src_ack_o   = 1'b0;
    case (src_state_q)
      HS_IDLE: begin
        // New request flips the phase, one edge per transfer
        if (src_req_i) begin
          src_toggle  = 1'b1;
          src_state_d = HS_BUSY;
        end
      end
      HS_BUSY: begin
        // Phases agree again once the destination has answered
        if (ack_phase == src_phase_q) begin
          src_ack_o   = 1'b1;
          src_state_d = HS_IDLE;
        end
      end
      default: src_state_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk_src_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      src_state_q <= HS_IDLE;
      src_phase_q <= 1'b0;
      ack_sync_q  <= '0;
    end else begin
      src_state_q <= src_state_d;
      src_phase_q <= src_phase_q ^ src_toggle;
      ack_sync_q  <= {ack_sync_q[`CDC_SYNC_STAGES-2:0], dst_phase_q};
    end
  end

  //////////////////////////////////////////////////
  // Destination domain
  //////////////////////////////////////////////////

  // Request phase as seen after the synchronizer
  assign req_phase = req_sync_q[`CDC_SYNC_STAGES-1];

  always_comb begin
    dst_state_d = dst_state_q;
    dst_toggle  = 1'b0;
    dst_req_o   = 1'b0;
    case (dst_state_q)
      HS_IDLE: begin
        // Differing phases mean a request is waiting
        if (req_phase != dst_phase_q) begin
          dst_state_d = HS_BUSY;
        end
      end
      HS_BUSY: begin
        dst_req_o = 1'b1;
        // Answer flips our phase back in line with the source
        if (dst_ack_i) begin
          dst_toggle  = 1'b1;
          dst_state_d = HS_IDLE;
        end
      end
      default: dst_state_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk_dst_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      dst_state_q <= HS_IDLE;
      dst_phase_q <= 1'b0;
      req_sync_q  <= '0;
    end else begin
      dst_state_q <= dst_state_d;
      dst_phase_q <= dst_phase_q ^ dst_toggle;
      req_sync_q  <= {req_sync_q[`CDC_SYNC_STAGES-2:0], src_phase_q};
    end
  end

  // Receiving port may only answer a visible request
  a_ack_with_req: assert property (
    @(posedge clk_dst_i) disable iff (!effective_rst_n)
    dst_ack_i |-> dst_req_o
  );

endmodule

//--- logic/sync_reqack_data.sv
`timescale 1ns/1ps

module sync_reqack_data #(
  parameter int unsigned Width       = 16,
  parameter bit          DataSrc2Dst = 1'b1,
  parameter bit          DataReg     = 1'b0
) (
  input logic     clk_src_i,
  input logic     clk_dst_i,
  input logic     effective_rst_n,
  xfer_if.sync_mp ch
);

  // Handshake crossing
  sync_reqack u_sync_reqack (
    .clk_src_i       (clk_src_i),
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .src_req_i       (ch.src_req),
    .src_ack_o       (ch.src_ack),
    .dst_req_o       (ch.dst_req),
    .dst_ack_i       (ch.dst_ack)
  );

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  if (DataSrc2Dst) begin : gen_src2dst
    // Source holds the word for the whole handshake
    assign ch.sync_data = ch.src_data;

    // Source word must not move while its request waits
    a_hold_src: assert property (
      @(posedge clk_src_i) disable iff (!effective_rst_n)
      ch.src_req && !ch.src_ack |=> $stable(ch.src_data)
    );
  end else if (DataReg) begin : gen_data_reg
    logic [Width-1:0] data_q;

    // Capture on the destination handshake
    always_ff @(posedge clk_dst_i or negedge effective_rst_n) begin
      if (!effective_rst_n) begin
        data_q <= '0;
      end else if (ch.dst_req && ch.dst_ack) begin
        data_q <= ch.dst_data;
      end
    end

    assign ch.sync_data = data_q;

    // Destination data must not move while its request is presented
    a_hold_reg: assert property (
      @(posedge clk_dst_i) disable iff (!effective_rst_n)
      ch.dst_req |-> $stable(ch.dst_data)
    );
  end else begin : gen_dst2src
    // Destination keeps its data until the source takes it
    assign ch.sync_data = ch.dst_data;

    a_hold_dst: assert property (
      @(posedge clk_dst_i) disable iff (!effective_rst_n)
      ch.dst_req |-> $stable(ch.dst_data)
    );
  end

  // Register stage only makes sense toward the source
  a_cfg: assert property (
    @(posedge clk_src_i)
    !(DataReg && DataSrc2Dst)
  );

endmodule

//--- logic/src_port.sv
`timescale 1ns/1ps

module src_port (
  input  logic           clk_src_i,
  input  logic           effective_rst_n,
  input  logic           src_wr_i,
  input  logic           src_rd_i,
  input  cdc_pkg::word_t src_wdata_i,
  output logic           src_busy_o,
  output logic           src_rd_valid_o,
  output cdc_pkg::stat_t src_rdata_o,
  xfer_if.src_mp         wr_ch,
  xfer_if.src_mp         rd_ch
);
  import cdc_pkg::*;

  logic  wr_pend_q;
  logic  rd_pend_q;
  logic  rd_valid_q;
  word_t wdata_q;
  stat_t rdata_q;

  // Any pending command blocks new strobes
  assign src_busy_o = wr_pend_q | rd_pend_q;

  // Command state
  always_ff @(posedge clk_src_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      wr_pend_q  <= 1'b0;
      rd_pend_q  <= 1'b0;
      rd_valid_q <= 1'b0;
      rdata_q    <= '0;
    end else begin
      rd_valid_q <= rd_ch.src_ack;
      // Write wins when both strobes arrive together
      if (!src_busy_o) begin
        if (src_wr_i) begin
          wr_pend_q <= 1'b1;
        end else if (src_rd_i) begin
          rd_pend_q <= 1'b1;
        end
      end
      if (wr_ch.src_ack) begin
        wr_pend_q <= 1'b0;
      end
      // Status arrives with the read acknowledge
      if (rd_ch.src_ack) begin
        rd_pend_q <= 1'b0;
        rdata_q   <= rd_ch.sync_data;
      end
    end
  end

  // Word is latched once per accepted write
  always_ff @(posedge clk_src_i) begin
    if (!src_busy_o && src_wr_i) begin
      wdata_q <= src_wdata_i;
    end
  end

  assign wr_ch.src_req  = wr_pend_q;
  assign wr_ch.src_data = wdata_q;
  // Read request carries no payload
  assign rd_ch.src_req  = rd_pend_q;
  assign rd_ch.src_data = '0;

  assign src_rd_valid_o = rd_valid_q;
  assign src_rdata_o    = rdata_q;

  // Request held with its word until the crossing answers
  a_wr_held: assert property (
    @(posedge clk_src_i) disable iff (!effective_rst_n)
    wr_pend_q && !wr_ch.src_ack |=> wr_pend_q && $stable(wdata_q)
  );

endmodule

//--- logic/dst_port.sv
`timescale 1ns/1ps

module dst_port (
  input  logic           clk_dst_i,
  input  logic           effective_rst_n,
  output cdc_pkg::word_t dst_reg_o,
  output logic           dst_wr_valid_o,
  xfer_if.dst_mp         wr_ch,
  xfer_if.dst_mp         rd_ch
);
  import cdc_pkg::*;

  word_t reg_q;
  cnt_t  cnt_q;
  logic  wr_valid_q;
  logic  wr_hs;

  // Requests are answered in their first cycle
  assign wr_ch.dst_ack = wr_ch.dst_req;
  assign rd_ch.dst_ack = rd_ch.dst_req;

  // Write completes on the destination handshake
  assign wr_hs = wr_ch.dst_req & wr_ch.dst_ack;

  //////////////////////////////////////////////////
  // Configuration register and write count
  //////////////////////////////////////////////////

  always_ff @(posedge clk_dst_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      reg_q      <= '0;
      cnt_q      <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_hs;
      if (wr_hs) begin
        reg_q <= wr_ch.sync_data;
        // Wraps at 256
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Write channel sends nothing back
  assign wr_ch.dst_data = '0;

  // Status is count then register, always presented
  assign rd_ch.dst_data = {cnt_q, reg_q};

  assign dst_reg_o      = reg_q;
  assign dst_wr_valid_o = wr_valid_q;

endmodule

//--- logic/cdc_reg_bridge.sv
`timescale 1ns/1ps
`include "cdc_params.svh"

module cdc_reg_bridge (
  input  logic           clk_src_i,
  input  logic           clk_dst_i,
  input  logic           effective_rst_n,
  input  logic           src_wr_i,
  input  logic           src_rd_i,
  input  cdc_pkg::word_t src_wdata_i,
  output logic           src_busy_o,
  output logic           src_rd_valid_o,
  output cdc_pkg::stat_t src_rdata_o,
  output logic           dst_wr_valid_o,
  output cdc_pkg::word_t dst_reg_o
);

  // Write channel carries the word toward the destination
  xfer_if #(.Width(`CDC_DATA_W)) wr_ch ();
  // Read channel brings the status back
  xfer_if #(.Width(`CDC_STAT_W)) rd_ch ();

  src_port u_src_port (
    .clk_src_i       (clk_src_i),
    .effective_rst_n (effective_rst_n),
    .src_wr_i        (src_wr_i),
    .src_rd_i        (src_rd_i),
    .src_wdata_i     (src_wdata_i),
    .src_busy_o      (src_busy_o),
    .src_rd_valid_o  (src_rd_valid_o),
    .src_rdata_o     (src_rdata_o),
    .wr_ch           (wr_ch.src_mp),
    .rd_ch           (rd_ch.src_mp)
  );

  sync_reqack_data #(
    .Width       (`CDC_DATA_W),
    .DataSrc2Dst (1'b1),
    .DataReg     (1'b0)
  ) u_wr_sync (
    .clk_src_i       (clk_src_i),
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .ch              (wr_ch.sync_mp)
  );

  // Status is registered in the destination before crossing back
  sync_reqack_data #(
    .Width       (`CDC_STAT_W),
    .DataSrc2Dst (1'b0),
    .DataReg     (1'b1)
  ) u_rd_sync (
    .clk_src_i       (clk_src_i),
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .ch              (rd_ch.sync_mp)
  );

  dst_port u_dst_port (
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .dst_reg_o       (dst_reg_o),
    .dst_wr_valid_o  (dst_wr_valid_o),
    .wr_ch           (wr_ch.dst_mp),
    .rd_ch           (rd_ch.dst_mp)
  );

endmodule

//--- tb/cdc_checker.sv
`timescale 1ns/1ps

module cdc_checker (
  input  logic           clk_src_i,
  input  logic           clk_dst_i,
  input  logic           effective_rst_n,
  input  logic           src_busy_i,
  input  logic           src_rd_valid_i,
  input  cdc_pkg::stat_t src_rdata_i,
  input  logic           dst_wr_valid_i,
  input  cdc_pkg::word_t dst_reg_i,
  input  logic           start_i,
  input  logic           done_i,
  input  int             idx_i,
  input  logic [7:0]     op_i,
  input  int             rep_i,
  input  cdc_pkg::stat_t exp_i,
  output int             pass_cnt_o,
  output int             fail_cnt_o
);
  import cdc_pkg::*;

  int    wr_total;
  int    rd_total;
  int    wr_base;
  int    rd_base;
  int    wr_seen;
  int    rd_seen;
  stat_t rd_last;
  logic  test_bad;
  logic  bad;
  logic  is_read;

  //////////////////////////////////////////////////
  // Event counters
  //////////////////////////////////////////////////

  // Write pulses live in the destination domain
  always @(posedge clk_dst_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      wr_total <= 0;
    end else if (dst_wr_valid_i) begin
      wr_total <= wr_total + 1;
    end
  end

  // Read results with the status they carried
  always @(posedge clk_src_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      rd_total <= 0;
      rd_last  <= '0;
    end else if (src_rd_valid_i) begin
      rd_total <= rd_total + 1;
      rd_last  <= src_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Per test comparison
  //////////////////////////////////////////////////

  always @(posedge clk_src_i or negedge effective_rst_n) begin
    if (!effective_rst_n) begin
      pass_cnt_o <= 0;
      fail_cnt_o <= 0;
      wr_base    <= 0;
      rd_base    <= 0;
      test_bad   <= 1'b0;
    end else begin
      // Bridge must be quiet when a command starts
      if (start_i) begin
        wr_base  <= wr_total;
        rd_base  <= rd_total;
        test_bad <= src_busy_i | src_rd_valid_i | dst_wr_valid_i;
        if (src_busy_i || src_rd_valid_i || dst_wr_valid_i) begin
          $display("test %0d: bridge was not idle when the command started", idx_i);
        end
      end
      if (done_i) begin
        bad     = test_bad;
        wr_seen = wr_total - wr_base;
        rd_seen = rd_total - rd_base;
        is_read = (op_i == 8'h01) || (op_i == 8'h03);
        if (is_read) begin
          if (rd_seen != rep_i) begin
            $display("test %0d: saw %0d read results, %0d expected", idx_i, rd_seen, rep_i);
            bad = 1'b1;
          end
          if (wr_seen != 0) begin
            $display("test %0d: %0d write pulses during a read", idx_i, wr_seen);
            bad = 1'b1;
          end
          if (rd_last !== exp_i) begin
            $display("MISMATCH test %0d src_rdata_o got 0x%06h expected 0x%06h",
                     idx_i, rd_last, exp_i);
            bad = 1'b1;
          end
        end else begin
          // Stray strobes while busy must not add pulses
          if (wr_seen != rep_i) begin
            $display("test %0d: saw %0d write pulses, %0d expected", idx_i, wr_seen, rep_i);
            bad = 1'b1;
          end
          if (rd_seen != 0) begin
            $display("test %0d: read result appeared during a write", idx_i);
            bad = 1'b1;
          end
          if (dst_reg_i !== exp_i[15:0]) begin
            $display("MISMATCH test %0d dst_reg_o got 0x%04h expected 0x%04h",
                     idx_i, dst_reg_i, exp_i[15:0]);
            bad = 1'b1;
          end
        end
        $display("test %0d op %0h: %s", idx_i, op_i, bad ? "failed" : "ok");
        if (bad) begin
          fail_cnt_o <= fail_cnt_o + 1;
        end else begin
          pass_cnt_o <= pass_cnt_o + 1;
        end
      end
    end
  end

endmodule

//--- tb/cdc_reg_bridge_tb.sv
`timescale 1ns/1ps

module cdc_reg_bridge_tb;
  import cdc_pkg::*;

  // Test list capacity and cycles allowed per wait
  localparam int MaxTests = 64;
  localparam int Timeout  = 50;

  logic        clk_src_i;
  logic        clk_dst_i;
  logic        effective_rst_n;
  logic        src_wr_i;
  logic        src_rd_i;
  word_t       src_wdata_i;
  logic        src_busy_o;
  logic        src_rd_valid_o;
  stat_t       src_rdata_o;
  logic        dst_wr_valid_o;
  word_t       dst_reg_o;

  // Current test as handed to the checker
  logic        start_test;
  logic        done_test;
  int          idx;
  logic [7:0]  op;
  int          rep;
  stat_t       exp_val;
  int          pass_cnt;
  int          fail_cnt;

  logic [23:0] tests_mem [0:4*MaxTests-1];
  logic [31:0] rng;
  int          t;
  logic        stop;
  logic        tmo;

  cdc_reg_bridge u_dut (
    .clk_src_i       (clk_src_i),
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .src_wr_i        (src_wr_i),
    .src_rd_i        (src_rd_i),
    .src_wdata_i     (src_wdata_i),
    .src_busy_o      (src_busy_o),
    .src_rd_valid_o  (src_rd_valid_o),
    .src_rdata_o     (src_rdata_o),
    .dst_wr_valid_o  (dst_wr_valid_o),
    .dst_reg_o       (dst_reg_o)
  );

  cdc_checker u_checker (
    .clk_src_i       (clk_src_i),
    .clk_dst_i       (clk_dst_i),
    .effective_rst_n (effective_rst_n),
    .src_busy_i      (src_busy_o),
    .src_rd_valid_i  (src_rd_valid_o),
    .src_rdata_i     (src_rdata_o),
    .dst_wr_valid_i  (dst_wr_valid_o),
    .dst_reg_i       (dst_reg_o),
    .start_i         (start_test),
    .done_i          (done_test),
    .idx_i           (idx),
    .op_i            (op),
    .rep_i           (rep),
    .exp_i           (exp_val),
    .pass_cnt_o      (pass_cnt),
    .fail_cnt_o      (fail_cnt)
  );

  //////////////////////////////////////////////////
  // Clocks, unrelated periods
  //////////////////////////////////////////////////

  initial begin
    clk_src_i = 1'b0;
    forever #50 clk_src_i = ~clk_src_i;
  end

  // Offset keeps destination edges off the source grid
  initial begin
    clk_dst_i = 1'b0;
    #13;
    forever #35 clk_dst_i = ~clk_dst_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Inputs change 1 ns after the source edge
  task automatic src_edge();
    @(posedge clk_src_i);
    #1;
  endtask

  task automatic wait_busy(input logic level, input string what, output logic timed_out);
    int cnt;
    cnt       = 0;
    timed_out = 1'b0;
    while (src_busy_o !== level && !timed_out) begin
      if (cnt >= Timeout) begin
        timed_out = 1'b1;
        $display("test %0d: timeout waiting for %s", idx, what);
      end else begin
        src_edge();
        cnt++;
      end
    end
  endtask

  task automatic run_test(input int n, output logic timed_out);
    logic [7:0] t_op;
    int         t_rep;
    word_t      t_word;
    int         gap;
    int         r;
    t_op      = tests_mem[4*n][7:0];
    t_rep     = int'(tests_mem[4*n+1]);
    t_word    = tests_mem[4*n+2][15:0];
    idx       = n;
    op        = t_op;
    rep       = t_rep;
    exp_val   = tests_mem[4*n+3];
    timed_out = 1'b0;
    start_test = 1'b1;
    r = 0;
    while (r < t_rep && !timed_out) begin
      // One cycle command strobe, op 4 raises both
      src_wdata_i = t_word;
      src_wr_i    = (t_op != 8'h01) && (t_op != 8'h03);
      src_rd_i    = (t_op == 8'h01) || (t_op == 8'h03) || (t_op == 8'h04);
      src_edge();
      src_wr_i   = 1'b0;
      src_rd_i   = 1'b0;
      start_test = 1'b0;
      // Stray strobes with a different word while busy
      if (t_op == 8'h02 || t_op == 8'h03) begin
        wait_busy(1'b1, "src_busy_o to rise", timed_out);
        if (!timed_out) begin
          src_wdata_i = ~t_word;
          src_wr_i    = 1'b1;
          src_rd_i    = 1'b1;
          src_edge();
          src_wr_i    = 1'b0;
          src_rd_i    = 1'b0;
        end
      end
      if (!timed_out) begin
        wait_busy(1'b0, "src_busy_o to fall", timed_out);
      end
      // Random idle gap of 0 to 3 cycles
      rng = xorshift32(rng);
      gap = int'(rng[1:0]);
      repeat (gap) src_edge();
      r++;
    end
    if (!timed_out) begin
      repeat (2) src_edge();
      done_test = 1'b1;
      src_edge();
      done_test = 1'b0;
      src_edge();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    effective_rst_n = 1'b0;
    src_wr_i        = 1'b0;
    src_rd_i        = 1'b0;
    src_wdata_i     = '0;
    start_test      = 1'b0;
    done_test       = 1'b0;
    idx             = 0;
    op              = '0;
    rep             = 0;
    exp_val         = '0;
    rng             = 32'd1;
    t               = 0;
    stop            = 1'b0;
    tmo             = 1'b0;
    $readmemh("tb/cdc_tests.txt", tests_mem);
    // Release lands between edges of both clocks
    repeat (8) @(posedge clk_src_i);
    #20;
    effective_rst_n = 1'b1;
    repeat (2) src_edge();
    while (!stop && !tmo && t < MaxTests) begin
      if (tests_mem[4*t][7:0] == 8'hff) begin
        stop = 1'b1;
      end else begin
        run_test(t, tmo);
        t++;
      end
    end
    $display("tests run %0d passed %0d failed %0d", t, pass_cnt, fail_cnt);
    if (!tmo && fail_cnt == 0 && pass_cnt == t) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb/cdc_tests.txt
// Columns in hex: op, repeat count, write word, expected register or status
// Op 0 write, 1 read, 2 write plus strobes while busy, 3 read plus strobes while busy,
// 4 write and read strobes together, ff end of list
1 1 0000 000000
0 1 1234 001234
1 1 0000 011234
0 1 abcd 00abcd
0 1 5a5a 005a5a
1 1 0000 035a5a
2 1 0f0f 000f0f
3 1 0000 040f0f
4 1 7777 007777
1 1 0000 057777
0 fa c3c3 00c3c3
1 1 0000 ffc3c3
0 1 0001 000001
1 1 0000 000001
0 3 beef 00beef
1 2 0000 03beef
ff 0 0000 000000

//--- cdc_reg_bridge.f
+incdir+logic
logic/cdc_pkg.sv
logic/xfer_if.sv
logic/sync_reqack.sv
logic/sync_reqack_data.sv
logic/src_port.sv
logic/dst_port.sv
logic/cdc_reg_bridge.sv
tb/cdc_checker.sv
tb/cdc_reg_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CDC register bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module cdc_reg_bridge_tb \
  -f cdc_reg_bridge.f -o cdc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cdc_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qxF '** PASS **' "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1
